//--- verilog/ras_pkg.sv
// shared widths and constants for the return address stack
// fetch block, flush and result structs
// 32-bit instruction window with J-type and I-type views

`default_nettype none

package ras_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int VADDR_W       = 32;
  localparam int FETCH_BYTES   = 8;
  localparam int SLOTS         = 4;
  localparam int SLOT_W        = 2;
  localparam int BLK_OFF_W     = $clog2(FETCH_BYTES);
  localparam int DEF_RAS_DEPTH = 8;

  // major opcodes of the standard jumps
  localparam logic [6:0] OPC_JAL  = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  typedef logic [VADDR_W-1:0] vaddr_t;

  // one block from the instruction cache
  typedef struct packed {
    logic                     valid;
    vaddr_t                   vaddr;
    logic [FETCH_BYTES*8-1:0] data;
    logic [FETCH_BYTES-1:0]   be;
  } fetch_resp_t;

  // --------------------
  // instruction views
  // --------------------
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  // same word, decoded as JAL or as JALR
  typedef union packed {
    inst_j_t j;
    inst_i_t i;
  } inst32_u;

  // window k ends at slot k, window 0 reaches back into the previous block
  typedef struct packed {
    inst32_u [SLOTS-1:0] win;
    logic                straddle_valid;
  } slot_windows_t;

  // --------------------
  // results and flush
  // --------------------
  typedef struct packed {
    logic              valid;
    logic [SLOT_W-1:0] slot;
    logic              direct;
    vaddr_t            target;
    vaddr_t            ret_addr;
  } call_info_t;

  typedef struct packed {
    logic              valid;
    logic [SLOT_W-1:0] slot;
    vaddr_t            ret_addr;
  } ret_info_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] ras_index;
  } ras_flush_t;

endpackage

`default_nettype wire

//--- verilog/fetch_boundary_tracker.sv
// fetch block boundary tracking
// keeps the upper halfword and straddle state of the last block
// builds the 32-bit windows and the starts-32 chain per slot

`default_nettype none

module fetch_boundary_tracker
  import ras_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_s2_valid,
  input  fetch_resp_t      i_s2_resp,
  output slot_windows_t    o_windows,
  output logic [SLOTS-1:0] o_starts_32
);

  logic [VADDR_W-1:BLK_OFF_W] r_next_blk;
  logic                       r_last_starts_32;
  logic [15:0]                r_prev_upper;

  logic                       w_fire;
  logic                       w_straddle;
  logic [SLOTS-1:0]           w_starts_32;

  assign w_fire = i_s2_valid & i_s2_resp.valid;

  // only a consecutive block can finish the pending instruction
  assign w_straddle = r_last_starts_32 &
                      (r_next_blk == i_s2_resp.vaddr[VADDR_W-1:BLK_OFF_W]);

  // --------------------
  // 32-bit start chain
  // --------------------
  always_comb begin
    logic prev_head;
    prev_head = w_straddle;
    for (int k = 0; k < SLOTS; k++) begin
      // a slot behind a 32-bit head is its upper half
      w_starts_32[k] = (i_s2_resp.data[k*16 +: 2] == 2'b11) & ~prev_head;
      prev_head      = w_starts_32[k];
    end
  end

  always_comb begin
    o_windows.straddle_valid = w_straddle;
    o_windows.win[0]         = {i_s2_resp.data[15:0], r_prev_upper};
    for (int k = 1; k < SLOTS; k++) begin
      o_windows.win[k] = i_s2_resp.data[(k-1)*16 +: 32];
    end
  end

  assign o_starts_32 = w_starts_32;

  // --------------------
  // block state
  // --------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_next_blk       <= '0;
      r_last_starts_32 <= 1'b0;
    end else if (w_fire) begin
      r_next_blk       <= i_s2_resp.vaddr[VADDR_W-1:BLK_OFF_W] + 1'b1;
      r_last_starts_32 <= w_starts_32[SLOTS-1];
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      r_prev_upper <= i_s2_resp.data[SLOTS*16-1 -: 16];
    end
  end

  // the decoder forms addresses from the block base
  a_block_aligned : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_fire |-> (i_s2_resp.vaddr[BLK_OFF_W-1:0] == '0))
    else $error("fetch block vaddr %h is not block aligned", i_s2_resp.vaddr);

endmodule

`default_nettype wire

//--- verilog/call_ret_decoder.sv
// call, return and jump decode over the four slots of a fetch block
// first-transfer selection
// call target and return address forming

`default_nettype none

module call_ret_decoder
  import ras_pkg::*;
(
  input  logic              i_s2_valid,
  input  fetch_resp_t       i_s2_resp,
  input  slot_windows_t     i_windows,
  input  logic [SLOTS-1:0]  i_starts_32,
  output call_info_t        o_call,
  output logic              o_ret_strobe,
  output logic [SLOT_W-1:0] o_ret_slot
);

  logic [SLOTS-1:0]  w_upper_half;
  logic [SLOTS-1:0]  w_call;
  logic [SLOTS-1:0]  w_ret;
  logic [SLOTS-1:0]  w_jump;
  logic [SLOTS-1:0]  w_direct;
  logic [SLOTS-1:0]  w_xfer;
  logic [SLOT_W-1:0] w_sel;
  inst32_u           w_sel_win;
  logic [15:0]       w_sel_rvc;
  vaddr_t            w_base;
  vaddr_t            w_slot_addr;
  vaddr_t            w_start;
  vaddr_t            w_offset;

  function automatic vaddr_t jal_imm(inst32_u w);
    return {{(VADDR_W-20){w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
  endfunction

  // c.jal offset, bits scattered across the halfword
  function automatic vaddr_t cj_imm(logic [15:0] c);
    return {{(VADDR_W-11){c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
  endfunction

  // slot k closes a 32-bit instruction
  assign w_upper_half = {i_starts_32[SLOTS-2:0], i_windows.straddle_valid};

  // --------------------
  // per-slot decode
  // --------------------
  always_comb begin
    logic [15:0] c;
    inst32_u     w;
    logic        en;
    logic        rvc_ok;
    logic        rvc_jal;
    logic        rvc_j;
    logic        rvc_jr;
    logic        rvc_jalr;
    logic        std_jal;
    logic        std_jalr;
    logic        std_ret;
    for (int k = 0; k < SLOTS; k++) begin
      c  = i_s2_resp.data[k*16 +: 16];
      w  = i_windows.win[k];
      en = i_s2_valid & i_s2_resp.valid & i_s2_resp.be[2*k];

      // standalone 16-bit instruction
      rvc_ok   = ~w_upper_half[k] & ~i_starts_32[k];
      rvc_jal  = rvc_ok & (c[1:0] == 2'b01) & (c[15:13] == 3'b001);
      rvc_j    = rvc_ok & (c[1:0] == 2'b01) & (c[15:13] == 3'b101);
      rvc_jr   = rvc_ok & (c[1:0] == 2'b10) & (c[15:12] == 4'b1000) &
                 (c[11:7] != 5'd0) & (c[6:2] == 5'd0);
      rvc_jalr = rvc_ok & (c[1:0] == 2'b10) & (c[15:12] == 4'b1001) &
                 (c[11:7] != 5'd0) & (c[6:2] == 5'd0);

      std_jal  = w_upper_half[k] & (w.j.opcode == OPC_JAL);
      std_jalr = w_upper_half[k] & (w.i.opcode == OPC_JALR) & (w.i.funct3 == 3'b000);
      // jalr x0, 0(x1)
      std_ret  = std_jalr & (w.i.rd == 5'd0) & (w.i.rs1 == 5'd1);

      // c.jalr always links through x1
      w_call[k]   = en & (rvc_jal | rvc_jalr |
                          (std_jal & (w.j.rd == 5'd1)) |
                          (std_jalr & (w.i.rd == 5'd1)));
      w_ret[k]    = en & ((rvc_jr & (c[11:7] == 5'd1)) | std_ret);
      w_jump[k]   = en & (rvc_j |
                          (rvc_jr & (c[11:7] != 5'd1)) |
                          (std_jal & (w.j.rd != 5'd1)) |
                          (std_jalr & (w.i.rd != 5'd1) & ~std_ret));
      w_direct[k] = rvc_jal | std_jal;
    end
  end

  assign w_xfer = w_call | w_ret | w_jump;

  // lowest transfer wins, later slots are shadowed
  always_comb begin
    w_sel = '0;
    for (int k = SLOTS - 1; k >= 0; k--) begin
      if (w_xfer[k]) begin
        w_sel = SLOT_W'(k);
      end
    end
  end

  // --------------------
  // address forming
  // --------------------
  assign w_sel_win   = i_windows.win[w_sel];
  assign w_sel_rvc   = i_s2_resp.data[w_sel*16 +: 16];
  assign w_base      = {i_s2_resp.vaddr[VADDR_W-1:BLK_OFF_W], {BLK_OFF_W{1'b0}}};
  assign w_slot_addr = w_base + vaddr_t'({w_sel, 1'b0});

  // a 32-bit call starts one halfword before the slot it closes
  assign w_start  = w_upper_half[w_sel] ? w_slot_addr - vaddr_t'(2) : w_slot_addr;
  assign w_offset = w_upper_half[w_sel] ? jal_imm(w_sel_win) : cj_imm(w_sel_rvc);

  always_comb begin
    o_call = '0;
    if (w_call[w_sel]) begin
      o_call.valid    = 1'b1;
      o_call.slot     = w_sel;
      o_call.direct   = w_direct[w_sel];
      o_call.target   = w_direct[w_sel] ? w_start + w_offset : '0;
      o_call.ret_addr = w_slot_addr + vaddr_t'(2);
    end
  end

  assign o_ret_strobe = w_ret[w_sel];
  assign o_ret_slot   = w_sel;

  // a closing halfword never starts another 32-bit instruction
  always_comb begin
    if (i_s2_valid) begin
      assert ((w_upper_half & i_starts_32) == '0)
        else $error("slot marked as both end and start of a 32-bit instruction");
    end
  end

endmodule

`default_nettype wire

//--- verilog/return_addr_stack.sv
// return address stack storage
// index update on flush, push and pop
// combinational read of the popped entry

`default_nettype none

module return_addr_stack
  import ras_pkg::*;
#(
  parameter int RAS_DEPTH = DEF_RAS_DEPTH
)
(
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  ras_flush_t                   i_flush,
  input  call_info_t                   i_call,
  input  logic                         i_ret_strobe,
  input  logic [SLOT_W-1:0]            i_ret_slot,
  output ret_info_t                    o_ret,
  output logic [$clog2(RAS_DEPTH)-1:0] o_ras_index
);

  localparam int IDX_W = $clog2(RAS_DEPTH);

  vaddr_t           r_stack [RAS_DEPTH];
  logic [IDX_W-1:0] r_index;

  logic             w_push;
  logic             w_pop;
  logic [IDX_W-1:0] w_work_idx;
  logic [IDX_W-1:0] w_pop_idx;
  logic [IDX_W-1:0] w_next_idx;

  // wrap modulo RAS_DEPTH, also for depths that are not a power of two
  function automatic logic [IDX_W-1:0] idx_inc(logic [IDX_W-1:0] idx);
    return (idx == IDX_W'(RAS_DEPTH - 1)) ? '0 : idx + 1'b1;
  endfunction

  function automatic logic [IDX_W-1:0] idx_dec(logic [IDX_W-1:0] idx);
    return (idx == '0) ? IDX_W'(RAS_DEPTH - 1) : idx - 1'b1;
  endfunction

  assign w_push = i_call.valid;
  assign w_pop  = i_ret_strobe;

  // --------------------
  // index update
  // --------------------
  // flush lands first, push or pop then works from it
  assign w_work_idx = i_flush.valid ? i_flush.ras_index[IDX_W-1:0] : r_index;
  assign w_pop_idx  = idx_dec(w_work_idx);

  always_comb begin
    w_next_idx = w_work_idx;
    if (w_pop) begin
      w_next_idx = w_pop_idx;
    end else if (w_push) begin
      w_next_idx = idx_inc(w_work_idx);
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_index <= '0;
    end else begin
      r_index <= w_next_idx;
    end
  end

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_stack[w_work_idx] <= i_call.ret_addr;
    end
  end

  // popped address is visible in the same cycle as the return
  assign o_ret.valid    = w_pop;
  assign o_ret.slot     = w_pop ? i_ret_slot : '0;
  assign o_ret.ret_addr = w_pop ? r_stack[w_pop_idx] : '0;

  assign o_ras_index = r_index;

  // first-transfer selection upstream keeps these exclusive
  a_no_push_pop : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_call.valid && i_ret_strobe))
    else $error("push and pop in the same cycle at index %0d", w_work_idx);

endmodule

`default_nettype wire

//--- verilog/ras_predictor_top.sv
// top level of the return address predictor
// boundary tracker, call and return decoder, stack

`default_nettype none

module ras_predictor_top
  import ras_pkg::*;
#(
  parameter int RAS_DEPTH = DEF_RAS_DEPTH
)
(
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_s2_valid,
  input  fetch_resp_t                  i_s2_resp,
  input  ras_flush_t                   i_flush,
  output call_info_t                   o_call,
  output ret_info_t                    o_ret,
  output logic [$clog2(RAS_DEPTH)-1:0] o_ras_index
);

  slot_windows_t     w_windows;
  logic [SLOTS-1:0]  w_starts_32;
  logic              w_ret_strobe;
  logic [SLOT_W-1:0] w_ret_slot;

  fetch_boundary_tracker u_tracker (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_s2_valid  (i_s2_valid),
    .i_s2_resp   (i_s2_resp),
    .o_windows   (w_windows),
    .o_starts_32 (w_starts_32)
  );

  call_ret_decoder u_decoder (
    .i_s2_valid   (i_s2_valid),
    .i_s2_resp    (i_s2_resp),
    .i_windows    (w_windows),
    .i_starts_32  (w_starts_32),
    .o_call       (o_call),
    .o_ret_strobe (w_ret_strobe),
    .o_ret_slot   (w_ret_slot)
  );

  // the reported call doubles as the push request
  return_addr_stack #(
    .RAS_DEPTH (RAS_DEPTH)
  ) u_stack (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_call       (o_call),
    .i_ret_strobe (w_ret_strobe),
    .i_ret_slot   (w_ret_slot),
    .o_ret        (o_ret),
    .o_ras_index  (o_ras_index)
  );

endmodule

`default_nettype wire

//--- test/tb_ras_vectors.svh
// stimulus and expected values, one row per cycle
// columns: filler, s2 valid, response, flush, expected call, expected return,
// expected stack index as seen during the row's cycle

`ifndef TB_RAS_VECTORS_SVH
`define TB_RAS_VECTORS_SVH

localparam int NUM_VEC = 25;

vec_t vectors [NUM_VEC];

function automatic void load_vectors();
  vectors[0]  = '{1'b1, 1'b1, make_block(32'h1000, '0), NO_FLUSH, NO_CALL, NO_RET, 3'd0};
  // jal x1,+0x100 in slots 0-1, reported where it closes
  vectors[1]  = '{1'b0, 1'b1, make_block(32'h1008, 64'h0001_0001_1000_00ef), NO_FLUSH,
                  expect_call(2'd1, 1'b1, 32'h1108, 32'h100c), NO_RET, 3'd0};
  vectors[2]  = '{1'b1, 1'b1, make_block(32'h2000, '0), NO_FLUSH, NO_CALL, NO_RET, 3'd1};
  vectors[3]  = '{1'b0, 1'b1, make_block(32'h3000, 64'h0001_0001_0000_8067), NO_FLUSH,
                  NO_CALL, expect_ret(2'd1, 32'h100c), 3'd1};
  vectors[4]  = '{1'b1, 1'b1, make_block(32'h3008, '0), NO_FLUSH, NO_CALL, NO_RET, 3'd0};
  // nested c.jal, jal and c.jalr x5
  vectors[5]  = '{1'b0, 1'b1, make_block(32'h4000, 64'h0001_0001_0001_2005), NO_FLUSH,
                  expect_call(2'd0, 1'b1, 32'h4020, 32'h4002), NO_RET, 3'd0};
  vectors[6]  = '{1'b0, 1'b1, make_block(32'h5000, 64'h1000_00ef_0001_0001), NO_FLUSH,
                  expect_call(2'd3, 1'b1, 32'h5104, 32'h5008), NO_RET, 3'd1};
  vectors[7]  = '{1'b0, 1'b1, make_block(32'h6000, 64'h0001_0001_9282_0001), NO_FLUSH,
                  expect_call(2'd1, 1'b0, 32'h0, 32'h6004), NO_RET, 3'd2};
  // unwinding in reverse order
  vectors[8]  = '{1'b0, 1'b1, make_block(32'h7000, 64'h0001_0001_0001_8082), NO_FLUSH,
                  NO_CALL, expect_ret(2'd0, 32'h6004), 3'd3};
  vectors[9]  = '{1'b0, 1'b1, make_block(32'h7008, 64'h0000_8067_0001_0001), NO_FLUSH,
                  NO_CALL, expect_ret(2'd3, 32'h5008), 3'd2};
  vectors[10] = '{1'b0, 1'b1, make_block(32'h7010, 64'h0001_0001_0001_8082), NO_FLUSH,
                  NO_CALL, expect_ret(2'd0, 32'h4002), 3'd1};
  // jal x1 split over two consecutive blocks
  vectors[11] = '{1'b0, 1'b1, make_block(32'h8000, 64'h00ef_0001_0001_0001), NO_FLUSH,
                  NO_CALL, NO_RET, 3'd0};
  vectors[12] = '{1'b0, 1'b1, make_block(32'h8008, 64'h0001_0001_0001_1000), NO_FLUSH,
                  expect_call(2'd0, 1'b1, 32'h8106, 32'h800a), NO_RET, 3'd0};
  vectors[13] = '{1'b0, 1'b1, make_block(32'h9000, 64'h00ef_0001_0001_0001), NO_FLUSH,
                  NO_CALL, NO_RET, 3'd1};
  // not the next block, so no straddle
  vectors[14] = '{1'b0, 1'b1, make_block(32'ha000, 64'h0001_0001_0001_1000), NO_FLUSH,
                  NO_CALL, NO_RET, 3'd1};
  // c.j ahead of c.jal hides the call
  vectors[15] = '{1'b0, 1'b1, make_block(32'hb000, 64'h0001_0001_2005_a001), NO_FLUSH,
                  NO_CALL, NO_RET, 3'd1};
  vectors[16] = '{1'b0, 1'b1, make_block(32'hc000, 64'h0001_0001_0001_2005), NO_FLUSH,
                  NO_CALL, NO_RET, 3'd1};
  vectors[16].resp.be = 8'hfc;
  vectors[17] = '{1'b0, 1'b1, make_block(32'hc008, 64'h0001_0001_0001_2005), NO_FLUSH,
                  NO_CALL, NO_RET, 3'd1};
  vectors[17].resp.valid = 1'b0;
  vectors[18] = '{1'b0, 1'b0, make_block(32'hc008, 64'h0001_0001_0001_2005), NO_FLUSH,
                  NO_CALL, NO_RET, 3'd1};
  // flush restores saved indices
  vectors[19] = '{1'b1, 1'b1, make_block(32'hd000, '0), '{1'b1, 8'd3}, NO_CALL, NO_RET, 3'd1};
  vectors[20] = '{1'b0, 1'b1, make_block(32'hd008, 64'h0001_0001_0001_8082), NO_FLUSH,
                  NO_CALL, expect_ret(2'd0, 32'h6004), 3'd3};
  vectors[21] = '{1'b0, 1'b1, make_block(32'hd010, 64'h0001_0001_0001_8082), '{1'b1, 8'd1},
                  NO_CALL, expect_ret(2'd0, 32'h800a), 3'd2};
  vectors[22] = '{1'b0, 1'b1, make_block(32'he000, 64'h0001_0001_0001_2005), '{1'b1, 8'd5},
                  expect_call(2'd0, 1'b1, 32'he020, 32'he002), NO_RET, 3'd0};
  vectors[23] = '{1'b0, 1'b1, make_block(32'he008, 64'h0001_0001_0001_8082), NO_FLUSH,
                  NO_CALL, expect_ret(2'd0, 32'he002), 3'd6};
  vectors[24] = '{1'b1, 1'b1, make_block(32'he010, '0), NO_FLUSH, NO_CALL, NO_RET, 3'd5};
endfunction

`endif

//--- test/tb_ras_predictor.sv
// testbench for the return address predictor
// clock and reset, table-driven stimulus loop
// compare tasks per result kind, cycle timeout

`default_nettype none

module tb_ras_predictor
  import ras_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAS_DEPTH = DEF_RAS_DEPTH;
  localparam int IDX_W     = $clog2(RAS_DEPTH);

  // quadrant 00 in every slot, so no jump and no 32-bit start
  localparam logic [63:0] NO_XFER_MASK = 64'hfffc_fffc_fffc_fffc;

  localparam ras_flush_t NO_FLUSH = '0;
  localparam call_info_t NO_CALL  = '0;
  localparam ret_info_t  NO_RET   = '0;

  // one table row, one cycle
  typedef struct packed {
    logic             fill;
    logic             s2_valid;
    fetch_resp_t      resp;
    ras_flush_t       flush;
    call_info_t       exp_call;
    ret_info_t        exp_ret;
    logic [IDX_W-1:0] exp_idx;
  } vec_t;

  logic             i_clk;
  logic             i_reset_n;
  logic             i_s2_valid;
  fetch_resp_t      i_s2_resp;
  ras_flush_t       i_flush;
  call_info_t       o_call;
  ret_info_t        o_ret;
  logic [IDX_W-1:0] o_ras_index;
  int               cycle_count = 0;

  // --------------------
  // row builders
  // --------------------
  function automatic fetch_resp_t make_block(vaddr_t addr, logic [63:0] data);
    fetch_resp_t r;
    r.valid = 1'b1;
    r.vaddr = addr;
    r.data  = data;
    r.be    = '1;
    return r;
  endfunction

  function automatic call_info_t expect_call(logic [SLOT_W-1:0] slot, logic direct,
                                             vaddr_t target, vaddr_t ret_addr);
    call_info_t c;
    c.valid    = 1'b1;
    c.slot     = slot;
    c.direct   = direct;
    c.target   = target;
    c.ret_addr = ret_addr;
    return c;
  endfunction

  function automatic ret_info_t expect_ret(logic [SLOT_W-1:0] slot, vaddr_t ret_addr);
    ret_info_t r;
    r.valid    = 1'b1;
    r.slot     = slot;
    r.ret_addr = ret_addr;
    return r;
  endfunction

  function automatic logic [63:0] filler_data();
    logic [63:0] d;
    d = {$urandom(), $urandom()};
    return d & NO_XFER_MASK;
  endfunction

  `include "tb_ras_vectors.svh"

  localparam int TIMEOUT_CYCLES = NUM_VEC + 20;

  ras_predictor_top #(
    .RAS_DEPTH (RAS_DEPTH)
  ) i_dut (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_s2_valid  (i_s2_valid),
    .i_s2_resp   (i_s2_resp),
    .i_flush     (i_flush),
    .o_call      (o_call),
    .o_ret       (o_ret),
    .o_ras_index (o_ras_index)
  );

  always #2 i_clk = ~i_clk;

  // --------------------
  // checks
  // --------------------
  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_call(call_info_t got, call_info_t exp, int row);
    if (got !== exp) begin
      fail_run($sformatf("Error: %0d ns: row %0d call got %p, expected %p",
                         $time, row, got, exp));
    end
  endtask

  task automatic check_ret(ret_info_t got, ret_info_t exp, int row);
    if (got !== exp) begin
      fail_run($sformatf("Error: %0d ns: row %0d return got %p, expected %p",
                         $time, row, got, exp));
    end
  endtask

  task automatic check_index(logic [IDX_W-1:0] got, logic [IDX_W-1:0] exp, int row);
    if (got !== exp) begin
      fail_run($sformatf("Error: %0d ns: row %0d stack index got %0d, expected %0d",
                         $time, row, got, exp));
    end
  endtask

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("timed out after %0d cycles before the table finished",
                         cycle_count));
    end
  end

  // filler rows get fresh random data at drive time
  task automatic apply_row(vec_t v);
    fetch_resp_t resp;
    resp = v.resp;
    if (v.fill) begin
      resp.data = filler_data();
    end
    i_s2_valid = v.s2_valid;
    i_s2_resp  = resp;
    i_flush    = v.flush;
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    i_clk      = 1'b0;
    i_reset_n  = 1'b0;
    i_s2_valid = 1'b0;
    i_s2_resp  = '0;
    i_flush    = '0;
    void'($urandom(68));
    load_vectors();
    repeat (5) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    for (int r = 0; r < NUM_VEC; r++) begin
      @(posedge i_clk);
      #1;
      apply_row(vectors[r]);
      // outputs settle well before the falling edge
      @(negedge i_clk);
      check_call(o_call, vectors[r].exp_call, r);
      check_ret(o_ret, vectors[r].exp_ret, r);
      check_index(o_ras_index, vectors[r].exp_idx, r);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+test
verilog/ras_pkg.sv
verilog/fetch_boundary_tracker.sv
verilog/call_ret_decoder.sv
verilog/return_addr_stack.sv
verilog/ras_predictor_top.sv
test/tb_ras_predictor.sv

//--- Makefile
# Verilator build and run of the return address predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_ras_predictor
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TB FAILED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) test/tb_ras_vectors.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "failure found in $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
	  echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
